/* common/riscv_cfg.svh */
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// data path and address width
`define RISCV_XLEN 32

// integer register file
`define RISCV_REG_COUNT 32
`define RISCV_REG_AW 5

// first instruction address after reset
`define RISCV_RESET_PC 32'h0000_0000

`endif

/* common/riscv_pkg.sv */
`include "riscv_cfg.svh"

package riscv_pkg;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } riscv_opcode_e;

  // one instruction word, viewed per encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [`RISCV_REG_AW-1:0] rs2;
      logic [`RISCV_REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [`RISCV_REG_AW-1:0] rd;
      riscv_opcode_e opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [`RISCV_REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [`RISCV_REG_AW-1:0] rd;
      riscv_opcode_e opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [`RISCV_REG_AW-1:0] rs2;
      logic [`RISCV_REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      riscv_opcode_e opcode;
    } s;
    struct packed {
      logic imm_12;
      logic [5:0] imm_10_5;
      logic [`RISCV_REG_AW-1:0] rs2;
      logic [`RISCV_REG_AW-1:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic imm_11;
      riscv_opcode_e opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [`RISCV_REG_AW-1:0] rd;
      riscv_opcode_e opcode;
    } u;
    struct packed {
      logic imm_20;
      logic [9:0] imm_10_1;
      logic imm_11;
      logic [7:0] imm_19_12;
      logic [`RISCV_REG_AW-1:0] rd;
      riscv_opcode_e opcode;
    } j;
  } riscv_inst_u;

  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, PASS_B
  } riscv_alu_op_e;

  typedef struct packed {
    riscv_alu_op_e alu_op;
    logic src_imm;    // operand b from immediate
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic branch;
    logic branch_ne;  // bne when set, beq otherwise
    logic jump;
    logic illegal;
  } riscv_ctrl_t;

  // wishbone classic master side
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [`RISCV_XLEN-1:0] adr;
    logic [`RISCV_XLEN-1:0] dat_w;
  } riscv_wb_req_t;

  typedef struct packed {
    logic ack;
    logic [`RISCV_XLEN-1:0] dat_r;
  } riscv_wb_rsp_t;

endpackage

/* compile.f */
+incdir+common
common/riscv_pkg.sv
core/riscv_decoder.sv
core/riscv_fetch.sv
core/riscv_lsu.sv
core/riscv_core.sv
rtl/riscv_bus_arbiter.sv
rtl/riscv_top.sv
sim/riscv_tb_clk.sv
sim/riscv_tb_mem.sv
sim/riscv_bus_chk.sv
sim/riscv_tb_top.sv

/* core/riscv_core.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_core (
  input  logic                    i_riscv_clk,
  input  logic                    i_rst_n,
  // fetch side
  output logic                    o_riscv_redirect,
  output logic [`RISCV_XLEN-1:0]  o_riscv_target,
  output logic                    o_riscv_take,
  input  logic                    i_riscv_inst_valid,
  input  riscv_pkg::riscv_inst_u  i_riscv_inst,
  input  logic [`RISCV_XLEN-1:0]  i_riscv_inst_pc,
  // lsu side
  output logic                    o_riscv_start,
  output logic                    o_riscv_we,
  output logic [`RISCV_XLEN-1:0]  o_riscv_addr,
  output logic [`RISCV_XLEN-1:0]  o_riscv_wdata,
  input  logic                    i_riscv_done,
  input  logic [`RISCV_XLEN-1:0]  i_riscv_rdata
);

  typedef enum logic [1:0] {IDLE, EXEC, MEM} state_e;

  state_e                   state_q;
  riscv_pkg::riscv_ctrl_t   ctrl;
  logic [`RISCV_XLEN-1:0]   imm;
  logic [`RISCV_XLEN-1:0]   regs [`RISCV_REG_COUNT];
  logic [`RISCV_XLEN-1:0]   rs1_val;
  logic [`RISCV_XLEN-1:0]   rs2_val;
  logic [`RISCV_XLEN-1:0]   op_b;
  logic [`RISCV_XLEN-1:0]   alu_res;
  logic                     taken;
  logic                     is_mem;
  logic                     load_q;   // pending lw writeback
  logic [`RISCV_REG_AW-1:0] ld_rd_q;
  logic                     rf_we;
  logic [`RISCV_REG_AW-1:0] rf_rd;
  logic [`RISCV_XLEN-1:0]   rf_wdata;

  riscv_decoder u_riscv_decoder (
    .i_riscv_inst (i_riscv_inst),
    .o_riscv_ctrl (ctrl),
    .o_riscv_imm  (imm)
  );

  assign rs1_val = regs[i_riscv_inst.r.rs1];
  assign rs2_val = regs[i_riscv_inst.r.rs2];
  assign op_b    = ctrl.src_imm ? imm : rs2_val;

  always_comb begin
    case (ctrl.alu_op)
      riscv_pkg::ADD:    alu_res = rs1_val + op_b;
      riscv_pkg::SUB:    alu_res = rs1_val - op_b;
      riscv_pkg::AND:    alu_res = rs1_val & op_b;
      riscv_pkg::OR:     alu_res = rs1_val | op_b;
      riscv_pkg::XOR:    alu_res = rs1_val ^ op_b;
      riscv_pkg::PASS_B: alu_res = op_b;  // lui
      default:           alu_res = '0;
    endcase
  end

  // beq / bne compare, jal always taken
  assign taken  = ctrl.jump | (ctrl.branch & ((rs1_val == rs2_val) ^ ctrl.branch_ne));
  assign is_mem = ctrl.mem_read | ctrl.mem_write;

  assign o_riscv_take     = (state_q == EXEC);
  assign o_riscv_redirect = (state_q == EXEC) & taken;
  assign o_riscv_target   = i_riscv_inst_pc + imm;
  assign o_riscv_start    = (state_q == EXEC) & is_mem;
  assign o_riscv_we       = ctrl.mem_write;
  assign o_riscv_addr     = alu_res;
  assign o_riscv_wdata    = rs2_val;

  always_comb begin
    if (state_q == MEM) begin
      rf_we    = i_riscv_done & load_q;
      rf_rd    = ld_rd_q;
      rf_wdata = i_riscv_rdata;
    end else begin
      rf_we    = (state_q == EXEC) & ctrl.reg_write & ~ctrl.mem_read;
      rf_rd    = i_riscv_inst.r.rd;
      rf_wdata = ctrl.jump ? i_riscv_inst_pc + `RISCV_XLEN'd4 : alu_res;  // link
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      for (int k = 0; k < `RISCV_REG_COUNT; k++)
        regs[k] <= '0;
    end else if (rf_we && rf_rd != '0) begin  // x0 stays zero
      regs[rf_rd] <= rf_wdata;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
      load_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (i_riscv_inst_valid) state_q <= EXEC;
        EXEC: begin
          state_q <= is_mem ? MEM : IDLE;
          load_q  <= ctrl.mem_read;
        end
        MEM:  if (i_riscv_done) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (state_q == EXEC)
      ld_rd_q <= i_riscv_inst.i.rd;
  end

endmodule

/* core/riscv_decoder.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_decoder (
  input  riscv_pkg::riscv_inst_u  i_riscv_inst,
  output riscv_pkg::riscv_ctrl_t  o_riscv_ctrl,
  output logic [`RISCV_XLEN-1:0]  o_riscv_imm
);

  always_comb begin
    o_riscv_ctrl = '0;
    o_riscv_ctrl.alu_op = riscv_pkg::ADD;
    o_riscv_imm = '0;
    case (i_riscv_inst.r.opcode)
      riscv_pkg::OP: begin
        o_riscv_ctrl.reg_write = 1'b1;
        if (i_riscv_inst.r.funct7 == 7'b0000000) begin
          case (i_riscv_inst.r.funct3)
            3'b000:  o_riscv_ctrl.alu_op = riscv_pkg::ADD;
            3'b111:  o_riscv_ctrl.alu_op = riscv_pkg::AND;
            3'b110:  o_riscv_ctrl.alu_op = riscv_pkg::OR;
            3'b100:  o_riscv_ctrl.alu_op = riscv_pkg::XOR;
            default: o_riscv_ctrl.illegal = 1'b1;  // shifts, slt
          endcase
        end else if (i_riscv_inst.r.funct7 == 7'b0100000 &&
                     i_riscv_inst.r.funct3 == 3'b000) begin
          o_riscv_ctrl.alu_op = riscv_pkg::SUB;
        end else begin
          o_riscv_ctrl.illegal = 1'b1;
        end
      end
      riscv_pkg::OP_IMM: begin
        o_riscv_ctrl.src_imm = 1'b1;
        o_riscv_ctrl.reg_write = 1'b1;
        o_riscv_ctrl.illegal = (i_riscv_inst.i.funct3 != 3'b000);  // addi only
        o_riscv_imm = {{(`RISCV_XLEN-12){i_riscv_inst.i.imm[11]}}, i_riscv_inst.i.imm};
      end
      riscv_pkg::LUI: begin
        o_riscv_ctrl.alu_op = riscv_pkg::PASS_B;
        o_riscv_ctrl.src_imm = 1'b1;
        o_riscv_ctrl.reg_write = 1'b1;
        o_riscv_imm = {i_riscv_inst.u.imm_31_12, 12'b0};
      end
      riscv_pkg::LOAD: begin
        o_riscv_ctrl.src_imm = 1'b1;
        o_riscv_ctrl.reg_write = 1'b1;
        o_riscv_ctrl.mem_read = 1'b1;
        o_riscv_ctrl.illegal = (i_riscv_inst.i.funct3 != 3'b010);  // lw only
        o_riscv_imm = {{(`RISCV_XLEN-12){i_riscv_inst.i.imm[11]}}, i_riscv_inst.i.imm};
      end
      riscv_pkg::STORE: begin
        o_riscv_ctrl.src_imm = 1'b1;
        o_riscv_ctrl.mem_write = 1'b1;
        o_riscv_ctrl.illegal = (i_riscv_inst.s.funct3 != 3'b010);  // sw only
        o_riscv_imm = {{(`RISCV_XLEN-12){i_riscv_inst.s.imm_11_5[6]}},
                       i_riscv_inst.s.imm_11_5, i_riscv_inst.s.imm_4_0};
      end
      riscv_pkg::BRANCH: begin
        o_riscv_ctrl.branch = 1'b1;
        o_riscv_ctrl.branch_ne = i_riscv_inst.b.funct3[0];
        o_riscv_ctrl.illegal = (i_riscv_inst.b.funct3[2:1] != 2'b00);
        o_riscv_imm = {{(`RISCV_XLEN-12){i_riscv_inst.b.imm_12}}, i_riscv_inst.b.imm_11,
                       i_riscv_inst.b.imm_10_5, i_riscv_inst.b.imm_4_1, 1'b0};
      end
      riscv_pkg::JAL: begin
        o_riscv_ctrl.jump = 1'b1;
        o_riscv_ctrl.reg_write = 1'b1;
        o_riscv_imm = {{(`RISCV_XLEN-20){i_riscv_inst.j.imm_20}}, i_riscv_inst.j.imm_19_12,
                       i_riscv_inst.j.imm_11, i_riscv_inst.j.imm_10_1, 1'b0};
      end
      default: o_riscv_ctrl.illegal = 1'b1;
    endcase
    // illegal word falls through as a nop
    if (o_riscv_ctrl.illegal) begin
      o_riscv_ctrl = '0;
      o_riscv_ctrl.alu_op = riscv_pkg::ADD;
      o_riscv_ctrl.illegal = 1'b1;
    end
  end

endmodule

/* core/riscv_fetch.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_fetch (
  input  logic                    i_riscv_clk,
  input  logic                    i_rst_n,
  input  logic                    i_riscv_redirect,
  input  logic [`RISCV_XLEN-1:0]  i_riscv_target,
  input  logic                    i_riscv_take,
  output logic                    o_riscv_inst_valid,
  output riscv_pkg::riscv_inst_u  o_riscv_inst,
  output logic [`RISCV_XLEN-1:0]  o_riscv_inst_pc,
  output riscv_pkg::riscv_wb_req_t o_riscv_req,
  input  riscv_pkg::riscv_wb_rsp_t i_riscv_rsp
);

  logic                   req_q;     // bus cycle open
  logic                   drop_q;    // in-flight word is stale
  logic [`RISCV_XLEN-1:0] adr_q;     // address on the bus
  logic [`RISCV_XLEN-1:0] pc_q;      // next address to fetch
  logic                   buf_valid_q;
  logic [`RISCV_XLEN-1:0] buf_inst_q;
  logic [`RISCV_XLEN-1:0] buf_pc_q;
  logic                   ack;
  logic                   fill;
  logic                   buf_valid_nxt;
  logic                   issue;
  logic [`RISCV_XLEN-1:0] issue_adr;

  assign ack  = req_q & i_riscv_rsp.ack;
  assign fill = ack & ~drop_q & ~i_riscv_redirect;  // word kept in buffer
  assign buf_valid_nxt = fill | (buf_valid_q & ~i_riscv_take & ~i_riscv_redirect);
  // no new request while the buffer stays full
  assign issue = (~req_q | ack) & ~buf_valid_nxt;
  assign issue_adr = i_riscv_redirect ? i_riscv_target : pc_q;

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      req_q       <= 1'b0;
      drop_q      <= 1'b0;
      pc_q        <= `RISCV_RESET_PC;
      buf_valid_q <= 1'b0;
    end else begin
      buf_valid_q <= buf_valid_nxt;
      if (issue) begin
        req_q <= 1'b1;
        pc_q  <= issue_adr + `RISCV_XLEN'd4;
      end else begin
        if (ack)
          req_q <= 1'b0;
        if (i_riscv_redirect)
          pc_q <= i_riscv_target;
      end
      if (ack)
        drop_q <= 1'b0;
      else if (i_riscv_redirect && req_q)
        drop_q <= 1'b1;  // finish the cycle, throw the word away
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (issue)
      adr_q <= issue_adr;
    if (fill) begin
      buf_inst_q <= i_riscv_rsp.dat_r;
      buf_pc_q   <= adr_q;
    end
  end

  always_comb begin
    o_riscv_req.cyc   = req_q;
    o_riscv_req.stb   = req_q;
    o_riscv_req.we    = 1'b0;  // read only
    o_riscv_req.adr   = adr_q;
    o_riscv_req.dat_w = '0;
  end

  assign o_riscv_inst_valid = buf_valid_q;
  assign o_riscv_inst       = buf_inst_q;
  assign o_riscv_inst_pc    = buf_pc_q;

endmodule

/* core/riscv_lsu.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_lsu (
  input  logic                     i_riscv_clk,
  input  logic                     i_rst_n,
  input  logic                     i_riscv_start,
  input  logic                     i_riscv_we,
  input  logic [`RISCV_XLEN-1:0]   i_riscv_addr,
  input  logic [`RISCV_XLEN-1:0]   i_riscv_wdata,
  output logic                     o_riscv_done,
  output logic [`RISCV_XLEN-1:0]   o_riscv_rdata,
  output riscv_pkg::riscv_wb_req_t o_riscv_req,
  input  riscv_pkg::riscv_wb_rsp_t i_riscv_rsp
);

  logic                   busy_q;
  logic                   done_q;
  logic                   we_q;
  logic [`RISCV_XLEN-1:0] adr_q;
  logic [`RISCV_XLEN-1:0] dat_q;
  logic [`RISCV_XLEN-1:0] rdata_q;
  logic                   ack;

  assign ack = busy_q & i_riscv_rsp.ack;

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= ack;  // one cycle pulse after ack
      if (!busy_q && i_riscv_start)
        busy_q <= 1'b1;
      else if (ack)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!busy_q && i_riscv_start) begin
      we_q  <= i_riscv_we;
      adr_q <= i_riscv_addr;
      dat_q <= i_riscv_wdata;
    end
    if (ack)
      rdata_q <= i_riscv_rsp.dat_r;
  end

  always_comb begin
    o_riscv_req.cyc   = busy_q;
    o_riscv_req.stb   = busy_q;
    o_riscv_req.we    = we_q;
    o_riscv_req.adr   = adr_q;
    o_riscv_req.dat_w = dat_q;
  end

  assign o_riscv_done  = done_q;
  assign o_riscv_rdata = rdata_q;

endmodule

/* rtl/riscv_bus_arbiter.sv */
`timescale 1ns/1ps

module riscv_bus_arbiter (
  input  logic                     i_riscv_clk,
  input  logic                     i_rst_n,
  input  riscv_pkg::riscv_wb_req_t i_riscv_fetch_req,
  output riscv_pkg::riscv_wb_rsp_t o_riscv_fetch_rsp,
  input  riscv_pkg::riscv_wb_req_t i_riscv_lsu_req,
  output riscv_pkg::riscv_wb_rsp_t o_riscv_lsu_rsp,
  output riscv_pkg::riscv_wb_req_t o_riscv_bus_req,
  input  riscv_pkg::riscv_wb_rsp_t i_riscv_bus_rsp
);

  logic busy_q;   // cycle open, owner locked
  logic owner_q;  // 1 = lsu
  logic grant_lsu;

  // lsu first when the port is idle
  assign grant_lsu = busy_q ? owner_q : i_riscv_lsu_req.cyc;

  always_comb begin
    o_riscv_bus_req = grant_lsu ? i_riscv_lsu_req : i_riscv_fetch_req;
    o_riscv_fetch_rsp.ack   = i_riscv_bus_rsp.ack & ~grant_lsu;
    o_riscv_fetch_rsp.dat_r = grant_lsu ? '0 : i_riscv_bus_rsp.dat_r;
    o_riscv_lsu_rsp.ack     = i_riscv_bus_rsp.ack & grant_lsu;
    o_riscv_lsu_rsp.dat_r   = grant_lsu ? i_riscv_bus_rsp.dat_r : '0;
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (o_riscv_bus_req.cyc && !i_riscv_bus_rsp.ack) begin
      busy_q  <= 1'b1;
      owner_q <= grant_lsu;
    end else begin
      busy_q  <= 1'b0;  // released on ack
    end
  end

endmodule

/* rtl/riscv_top.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_top (
  input  logic                     i_riscv_clk,
  input  logic                     i_rst_n,
  output riscv_pkg::riscv_wb_req_t o_riscv_wb_req,
  input  riscv_pkg::riscv_wb_rsp_t i_riscv_wb_rsp
);

  logic                     redirect;
  logic [`RISCV_XLEN-1:0]   target;
  logic                     take;
  logic                     inst_valid;
  riscv_pkg::riscv_inst_u   inst;
  logic [`RISCV_XLEN-1:0]   inst_pc;
  logic                     lsu_start;
  logic                     lsu_we;
  logic [`RISCV_XLEN-1:0]   lsu_addr;
  logic [`RISCV_XLEN-1:0]   lsu_wdata;
  logic                     lsu_done;
  logic [`RISCV_XLEN-1:0]   lsu_rdata;
  riscv_pkg::riscv_wb_req_t fetch_req;
  riscv_pkg::riscv_wb_rsp_t fetch_rsp;
  riscv_pkg::riscv_wb_req_t lsu_req;
  riscv_pkg::riscv_wb_rsp_t lsu_rsp;

  riscv_core u_riscv_core (
    .i_riscv_clk        (i_riscv_clk),
    .i_rst_n            (i_rst_n),
    .o_riscv_redirect   (redirect),
    .o_riscv_target     (target),
    .o_riscv_take       (take),
    .i_riscv_inst_valid (inst_valid),
    .i_riscv_inst       (inst),
    .i_riscv_inst_pc    (inst_pc),
    .o_riscv_start      (lsu_start),
    .o_riscv_we         (lsu_we),
    .o_riscv_addr       (lsu_addr),
    .o_riscv_wdata      (lsu_wdata),
    .i_riscv_done       (lsu_done),
    .i_riscv_rdata      (lsu_rdata)
  );

  riscv_fetch u_riscv_fetch (
    .i_riscv_clk        (i_riscv_clk),
    .i_rst_n            (i_rst_n),
    .i_riscv_redirect   (redirect),
    .i_riscv_target     (target),
    .i_riscv_take       (take),
    .o_riscv_inst_valid (inst_valid),
    .o_riscv_inst       (inst),
    .o_riscv_inst_pc    (inst_pc),
    .o_riscv_req        (fetch_req),
    .i_riscv_rsp        (fetch_rsp)
  );

  riscv_lsu u_riscv_lsu (
    .i_riscv_clk   (i_riscv_clk),
    .i_rst_n       (i_rst_n),
    .i_riscv_start (lsu_start),
    .i_riscv_we    (lsu_we),
    .i_riscv_addr  (lsu_addr),
    .i_riscv_wdata (lsu_wdata),
    .o_riscv_done  (lsu_done),
    .o_riscv_rdata (lsu_rdata),
    .o_riscv_req   (lsu_req),
    .i_riscv_rsp   (lsu_rsp)
  );

  riscv_bus_arbiter u_riscv_bus_arbiter (
    .i_riscv_clk       (i_riscv_clk),
    .i_rst_n           (i_rst_n),
    .i_riscv_fetch_req (fetch_req),
    .o_riscv_fetch_rsp (fetch_rsp),
    .i_riscv_lsu_req   (lsu_req),
    .o_riscv_lsu_rsp   (lsu_rsp),
    .o_riscv_bus_req   (o_riscv_wb_req),
    .i_riscv_bus_rsp   (i_riscv_wb_rsp)
  );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module riscv_tb_top -o riscv_tb
./obj_dir/riscv_tb

/* sim/riscv_bus_chk.sv */
`timescale 1ns/1ps

module riscv_bus_chk (
  input logic                     i_clk,
  input logic                     i_rst_n,
  input riscv_pkg::riscv_wb_req_t i_fetch_req,
  input riscv_pkg::riscv_wb_rsp_t i_fetch_rsp,
  input riscv_pkg::riscv_wb_req_t i_lsu_req,
  input riscv_pkg::riscv_wb_rsp_t i_lsu_rsp,
  input riscv_pkg::riscv_wb_req_t i_bus_req,
  input riscv_pkg::riscv_wb_rsp_t i_bus_rsp
);

  a_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_bus_req.stb |-> i_bus_req.cyc)
    else $error("stb without cyc");

  // open cycle holds its fields until ack
  a_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_bus_req.cyc && !i_bus_rsp.ack) |=>
      (i_bus_req.cyc && $stable(i_bus_req.adr) && $stable(i_bus_req.we) &&
       $stable(i_bus_req.dat_w)))
    else $error("request changed before ack");

  a_ack_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!i_fetch_rsp.ack || i_fetch_req.cyc) && (!i_lsu_rsp.ack || i_lsu_req.cyc))
    else $error("ack to a requester that did not ask");

  a_one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_fetch_rsp.ack && i_lsu_rsp.ack))
    else $error("both requesters acked");

endmodule

bind riscv_bus_arbiter riscv_bus_chk u_riscv_bus_chk (
  .i_clk       (i_riscv_clk),
  .i_rst_n     (i_rst_n),
  .i_fetch_req (i_riscv_fetch_req),
  .i_fetch_rsp (o_riscv_fetch_rsp),
  .i_lsu_req   (i_riscv_lsu_req),
  .i_lsu_rsp   (o_riscv_lsu_rsp),
  .i_bus_req   (o_riscv_bus_req),
  .i_bus_rsp   (i_riscv_bus_rsp)
);

/* sim/riscv_tb_clk.sv */
`timescale 1ns/1ps

module riscv_tb_clk (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #10 o_clk = ~o_clk;  // 20 ns period

endmodule

/* sim/riscv_tb_mem.sv */
`timescale 1ns/1ps

module riscv_tb_mem (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_wait_en,
  input  riscv_pkg::riscv_wb_req_t i_req,
  output riscv_pkg::riscv_wb_rsp_t o_rsp
);

  logic [31:0] mem [1024];
  logic [1:0]  wait_cnt;
  logic [1:0]  wait_tgt;  // extra cycles before ack
  integer      seed;

  initial begin
    seed  = 32'hbdd5f113;
    o_rsp = '0;
    wait_cnt = '0;
    wait_tgt = '0;
  end

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_rsp.ack <= 1'b0;
      wait_cnt  <= '0;
      wait_tgt  <= '0;
    end else if (o_rsp.ack) begin
      o_rsp.ack <= 1'b0;  // one ack per transfer
    end else if (i_req.cyc && i_req.stb) begin
      if (wait_cnt == wait_tgt) begin
        o_rsp.ack <= 1'b1;
        wait_cnt  <= '0;
        wait_tgt  <= i_wait_en ? 2'($random(seed)) : 2'd0;
        if (i_req.we)
          mem[i_req.adr[11:2]] <= i_req.dat_w;
        else
          o_rsp.dat_r <= mem[i_req.adr[11:2]];
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  // background pattern, unique per word
  task automatic fill_pattern();
    for (int k = 0; k < 1024; k++)
      mem[k] = 32'ha5a5_0000 | k;
  endtask

  task automatic write_word(input int idx, input logic [31:0] w);
    mem[idx] = w;
  endtask

endmodule

/* sim/riscv_tb_top.sv */
`timescale 1ns/1ps

module riscv_tb_top;

  localparam int STORES_PER_ROUND = 11;
  localparam int NUM_TESTS = 7;

  logic clk;
  logic rst_n;
  logic wait_en;
  riscv_pkg::riscv_wb_req_t wb_req;
  riscv_pkg::riscv_wb_rsp_t wb_rsp;
  logic [31:0] prog [$];
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  logic [31:0] got_adr [$];
  logic [31:0] got_dat [$];
  int errors;

  riscv_tb_clk u_clk (.o_clk(clk));

  riscv_tb_mem u_mem (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_wait_en (wait_en),
    .i_req     (wb_req),
    .o_rsp     (wb_rsp)
  );

  riscv_top i_dut (
    .i_riscv_clk    (clk),
    .i_rst_n        (rst_n),
    .o_riscv_wb_req (wb_req),
    .i_riscv_wb_rsp (wb_rsp)
  );

  // record completed write cycles at the port
  always @(posedge clk) begin
    if (rst_n && wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
      got_adr.push_back(wb_req.adr);
      got_dat.push_back(wb_req.dat_w);
    end
  end

  function automatic logic [31:0] enc_i(input logic [6:0] op, input int rd, input int f3,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                        input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      fail_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
    end
  endtask

  // load prog under reset, release and check the first fetch
  task automatic reset_and_load();
    @(posedge clk) rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    u_mem.fill_pattern();
    foreach (prog[k])
      u_mem.write_word(k, prog[k]);
    got_adr.delete();
    got_dat.delete();
    repeat (6) begin
      @(posedge clk);
      assert (!wb_req.cyc) else fail_run("bus cycle opened during reset");
    end
    rst_n <= 1'b1;
    @(posedge clk);
    while (!wb_req.cyc) @(posedge clk);
    check_value("wb_req.adr", wb_req.adr, 32'h0);
    check_value("wb_req.we", 32'(wb_req.we), 32'h0);
  endtask

  task automatic run_and_compare(input string name);
    reset_and_load();
    while (got_adr.size() < exp_adr.size()) @(posedge clk);
    repeat (50) @(posedge clk);  // no stray stores afterwards
    check_value({name, " store count"}, got_adr.size(), exp_adr.size());
    foreach (exp_adr[k]) begin
      check_value($sformatf("%s wb_req.adr[%0d]", name, k), got_adr[k], exp_adr[k]);
      check_value($sformatf("%s wb_req.dat_w[%0d]", name, k), got_dat[k], exp_dat[k]);
    end
  endtask

  task automatic test_reset();
    prog = '{enc_j(0, 0)};
    exp_adr.delete();
    exp_dat.delete();
    run_and_compare("reset");
  endtask

  task automatic test_arith();
    int a;
    int b;
    a = 100;
    b = -7;
    prog = '{enc_i(7'b0010011, 1, 0, 0, a), enc_i(7'b0010011, 2, 0, 0, b),
             enc_r(0, 0, 3, 1, 2), enc_r(7'h20, 0, 4, 1, 2), enc_r(0, 7, 5, 1, 2),
             enc_r(0, 6, 6, 1, 2), enc_r(0, 4, 7, 1, 2),
             {20'h12345, 5'd8, 7'b0110111},
             enc_i(7'b0010011, 0, 0, 1, 5),  // write to x0 is dropped
             enc_s(3, 0, 'h400), enc_s(4, 0, 'h404), enc_s(5, 0, 'h408),
             enc_s(6, 0, 'h40c), enc_s(7, 0, 'h410), enc_s(8, 0, 'h414),
             enc_s(0, 0, 'h418), enc_j(0, 0)};
    exp_adr = '{32'h400, 32'h404, 32'h408, 32'h40c, 32'h410, 32'h414, 32'h418};
    exp_dat = '{a + b, a - b, a & b, a | b, a ^ b, 32'h12345 << 12, 32'h0};
    run_and_compare("arith");
  endtask

  task automatic test_load_store();
    prog = '{enc_i(7'b0010011, 1, 0, 0, 'h55), enc_s(1, 0, 'h500),
             enc_i(7'b0000011, 2, 2, 0, 'h500), enc_i(7'b0010011, 2, 0, 2, 1),
             enc_s(2, 0, 'h504), enc_j(0, 0)};
    exp_adr = '{32'h500, 32'h504};
    exp_dat = '{32'h55, 32'h55 + 1};
    run_and_compare("load_store");
  endtask

  task automatic test_branch();
    prog = '{enc_i(7'b0010011, 1, 0, 0, 1),  // 0
             enc_i(7'b0010011, 2, 0, 0, 2),  // 4
             enc_b(0, 1, 1, 8),              // 8 beq taken
             enc_s(1, 0, 'h600),             // 12 skipped
             enc_b(0, 1, 2, 8),              // 16 beq not taken
             enc_s(2, 0, 'h604),             // 20
             enc_b(1, 1, 2, 8),              // 24 bne taken
             enc_s(1, 0, 'h608),             // 28 skipped
             enc_j(5, 8),                    // 32 jal, link in x5
             enc_s(1, 0, 'h60c),             // 36 skipped
             enc_s(5, 0, 'h610),             // 40
             enc_j(0, 0)};
    exp_adr = '{32'h604, 32'h610};
    exp_dat = '{32'h2, 32'd32 + 4};
    run_and_compare("branch");
  endtask

  initial begin
    rst_n   = 1'b0;
    wait_en = 1'b0;
    errors  = 0;
    test_reset();
    test_arith();
    test_load_store();
    test_branch();
    @(posedge clk) wait_en <= 1'b1;  // random wait states from here
    test_arith();
    test_load_store();
    test_branch();
    if (errors == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1);
    end
  end

  initial begin
    repeat (200 * STORES_PER_ROUND * NUM_TESTS) @(posedge clk);
    $display("the run hung and did not finish in time");
    $display("Some tests failed");
    $fatal(1);
  end

endmodule
